/* Makefile */
VERILATOR ?= verilator
TOP       ?= mpls_proc_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
+incdir+design
design/mpls_pkg.sv
design/word_fifo.sv
design/route_select.sv
design/label_rewrite.sv
design/egress_sequencer.sv
design/mpls_proc.sv
test/tb_clock.sv
test/mpls_proc_tb.sv

/* design/egress_sequencer.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module egress_sequencer
   import mpls_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  pkt_word_t  head,
   input  logic       empty,
   input  route_t     route,
   input  pkt_word_t  edit_word,
   input  logic       out_rdy,
   output logic       pop,
   output logic       hdr_take,
   output logic [1:0] word_idx,
   output pkt_word_t  out_word,
   output logic       out_wr
);

   logic      is_hdr;
   logic      is_end;
   logic      past_w3;    // beyond word 3 with nothing left to edit
   pkt_word_t next_word;

   assign is_hdr   = (head.ctrl == `HDR_CTRL);
   assign is_end   = (head.ctrl != '0) && !is_hdr;
   assign pop      = out_rdy && !empty;      // one word per cycle
   assign hdr_take = pop && is_hdr;

   //////////////////////
   // word select
   always_comb begin
      next_word = edit_word;
      if (is_hdr) begin
         next_word = head;
         next_word.data[`DST_PORT_POS +: 8] = route.dst_port;
      end else if (past_w3) begin
         next_word = head;
      end
   end

   //////////////////////
   // word index in packet
   always_ff @(posedge clk) begin
      if (reset) begin
         word_idx <= 2'd0;
         past_w3  <= 1'b0;
      end else if (pop) begin
         if (is_end) begin
            word_idx <= 2'd0;
            past_w3  <= 1'b0;
         end else if (word_idx == 2'd3) begin
            past_w3 <= 1'b1;        // index saturates
         end else begin
            word_idx <= word_idx + 2'd1;
         end
      end
   end

   // output register
   always_ff @(posedge clk) begin
      if (reset) begin
         out_wr <= 1'b0;
      end else begin
         out_wr <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         out_word <= next_word;
      end
   end

   // a header only ever starts a packet
   a_hdr_at_start: assert property (@(posedge clk) disable iff (reset)
      hdr_take |-> (word_idx == 2'd0) && !past_w3);

endmodule

`default_nettype wire

/* design/label_rewrite.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module label_rewrite
   import mpls_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  pkt_word_t              head,
   input  logic [1:0]             word_idx,
   input  logic                   hdr_take,
   input  route_t                 route,
   input  logic [`MPLSWORD_W-1:0] mplsword,
   input  logic [`MAC_W-1:0]      bram_dst_mac,
   output pkt_word_t              edit_word
);

   mpls_cmd_t cmd_q;
   logic      mpls_q;     // ethertype seen on word 2
   logic      mpls_now;
   logic      swap;

   assign mpls_now = (head.data[31:16] == `ETHTYPE_MPLS);
   assign swap     = (cmd_q.cmd == 4'd1);   // anything else acts as 0

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_q  <= '0;
         mpls_q <= 1'b0;
      end else begin
         if (hdr_take) begin
            cmd_q <= decode_cmd(mplsword);  // sideband valid until header leaves
         end
         if (word_idx == 2'd2) begin
            mpls_q <= mpls_now;    // last value is the real word 2
         end
      end
   end

   //////////////////////
   // word edits, unicast only
   always_comb begin
      edit_word = head;
      if (route.unicast) begin
         case (word_idx)
            2'd1: begin
               edit_word.data[`DATA_W-1 -: `MAC_W] = bram_dst_mac;
            end
            2'd2: begin
               if (mpls_now && swap) begin
                  edit_word.data[15:0] = cmd_q.swap_label[19:4];  // label high part
               end
            end
            2'd3: begin
               if (mpls_q) begin
                  if (swap) begin
                     edit_word.data[63:60] = cmd_q.swap_label[3:0];
                  end
                  edit_word.data[55:48] = head.data[55:48] - 8'd1;  // ttl
               end
            end
            default: begin
               edit_word = head;   // header untouched here
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/mpls_defs.svh */
`ifndef MPLS_DEFS_SVH
`define MPLS_DEFS_SVH
`default_nettype none

//////////////////////
// datapath word
`define DATA_W          64
`define CTRL_W          8
`define HDR_CTRL        8'hff     // module header marker

// module header fields
`define DST_PORT_POS    48        // one-hot output port byte
`define SRC_PORT_POS    16        // 3-bit input port

//////////////////////
// mpls
`define ETHTYPE_MPLS    16'h8847
`define MPLSWORD_W      72        // command word from the table
`define MAC_W           48

// input fifo holds 2**FIFO_DEPTH_BITS words
`define FIFO_DEPTH_BITS 5

`default_nettype wire
`endif

/* design/mpls_pkg.sv */
`include "mpls_defs.svh"
`default_nettype none

package mpls_pkg;

   // one word of the datapath, ctrl on top as on the bus
   typedef struct packed {
      logic [`CTRL_W-1:0] ctrl;
      logic [`DATA_W-1:0] data;
   } pkt_word_t;

   typedef struct packed {
      logic       unicast;   // 0 means cpu path
      logic [7:0] dst_port;  // one-hot
   } route_t;

   typedef struct packed {
      logic [3:0]  cmd;
      logic [19:0] swap_label;
      logic [2:0]  out_port;
   } mpls_cmd_t;

   // pull the used fields out of the table command word
   function automatic mpls_cmd_t decode_cmd(input logic [`MPLSWORD_W-1:0] word);
      mpls_cmd_t c;
      c.cmd        = word[71:68];
      c.swap_label = word[49:30];
      c.out_port   = word[60:58];
      return c;
   endfunction

endpackage

`default_nettype wire

/* design/mpls_proc.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mpls_proc
   import mpls_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // input side
   input  pkt_word_t              in_word,
   input  logic                   in_wr,
   output logic                   in_rdy,
   // output side
   output pkt_word_t              out_word,
   output logic                   out_wr,
   input  logic                   out_rdy,
   // table sideband, per packet at the fifo head
   input  logic [`MAC_W-1:0]      bram_dst_mac,
   input  logic [`MPLSWORD_W-1:0] mplsword,
   input  logic                   unicast_out,
   input  logic [7:0]             ttl_stat_out
);

   pkt_word_t  head;
   pkt_word_t  edit_word;
   route_t     route;
   mpls_cmd_t  cmd_now;
   logic       fifo_empty;
   logic       fifo_nearly_full;
   logic       pop;
   logic       hdr_take;
   logic [1:0] word_idx;

   assign in_rdy  = !fifo_nearly_full;
   assign cmd_now = decode_cmd(mplsword);

   word_fifo u_fifo (
      .clk(clk), .reset(reset), .din(in_word), .wr_en(in_wr), .rd_en(pop),
      .dout(head), .empty(fifo_empty), .nearly_full(fifo_nearly_full)
   );

   route_select u_route (
      .clk(clk), .reset(reset), .head(head), .hdr_take(hdr_take),
      .unicast_out(unicast_out), .ttl_stat_out(ttl_stat_out),
      .out_port(cmd_now.out_port), .route(route)
   );

   label_rewrite u_rewrite (
      .clk(clk), .reset(reset), .head(head), .word_idx(word_idx),
      .hdr_take(hdr_take), .route(route), .mplsword(mplsword),
      .bram_dst_mac(bram_dst_mac), .edit_word(edit_word)
   );

   egress_sequencer u_egress (
      .clk(clk), .reset(reset), .head(head), .empty(fifo_empty), .route(route),
      .edit_word(edit_word), .out_rdy(out_rdy), .pop(pop), .hdr_take(hdr_take),
      .word_idx(word_idx), .out_word(out_word), .out_wr(out_wr)
   );

endmodule

`default_nettype wire

/* design/route_select.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module route_select
   import mpls_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  pkt_word_t  head,
   input  logic       hdr_take,
   input  logic       unicast_out,
   input  logic [7:0] ttl_stat_out,
   input  logic [2:0] out_port,
   output route_t     route
);

   route_t     route_q;     // held for the rest of the packet
   route_t     route_hdr;
   logic       to_cpu;
   logic [2:0] cpu_port;

   // ttl about to expire goes to the cpu as well
   assign to_cpu   = !unicast_out || (ttl_stat_out <= 8'd1);
   assign cpu_port = head.data[`SRC_PORT_POS +: 3] + 3'd1;  // wraps mod 8

   always_comb begin
      route_hdr.unicast = !to_cpu;
      if (to_cpu) begin
         route_hdr.dst_port = 8'b1 << cpu_port;
      end else begin
         route_hdr.dst_port = 8'b1 << out_port;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         route_q <= '0;
      end else if (hdr_take) begin
         route_q <= route_hdr;
      end
   end

   // header cycle sees the fresh decision
   assign route = hdr_take ? route_hdr : route_q;

endmodule

`default_nettype wire

/* design/word_fifo.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module word_fifo
   import mpls_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  pkt_word_t din,
   input  logic      wr_en,
   input  logic      rd_en,
   output pkt_word_t dout,
   output logic      empty,
   output logic      nearly_full
);

   localparam int AW = `FIFO_DEPTH_BITS;
   localparam logic [AW:0] FULL_LVL = AW'(0) + (AW+1)'(1 << AW);
   localparam logic [AW:0] NF_LVL   = FULL_LVL - (AW+1)'(2);  // two slots left

   pkt_word_t   mem [1 << AW];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;

   assign dout        = mem[rd_ptr];   // fall-through head
   assign empty       = (count == '0);
   assign full        = (count == FULL_LVL);
   assign nearly_full = (count >= NF_LVL);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + AW'(1);
         if (rd_en) rd_ptr <= rd_ptr + AW'(1);
         case ({wr_en, rd_en})
            2'b10:   count <= count + (AW+1)'(1);
            2'b01:   count <= count - (AW+1)'(1);
            default: count <= count;    // both or neither
         endcase
      end
   end

   // upstream must respect in_rdy, egress must respect empty
   a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty);

endmodule

`default_nettype wire

/* test/mpls_proc_tb.sv */
`include "mpls_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mpls_proc_tb
   import mpls_pkg::*;
();

   localparam logic [31:0] SEED = 32'h2da5;
   localparam int NUM_PKTS   = 60;
   localparam int WAIT_LIMIT = 2000;    // cycles per wait
   localparam int NUM_KINDS  = 6;

   logic                   clk;
   logic                   reset;
   pkt_word_t              in_word;
   logic                   in_wr;
   logic                   in_rdy;
   pkt_word_t              out_word;
   logic                   out_wr;
   logic                   out_rdy;
   logic [`MAC_W-1:0]      bram_dst_mac;
   logic [`MPLSWORD_W-1:0] mplsword;
   logic                   unicast_out;
   logic [7:0]             ttl_stat_out;

   logic [31:0] rng;
   logic [31:0] rdy_rng;       // own stream for back-pressure
   logic        rdy_at_edge;   // out_rdy seen by the dut at the last edge
   logic        timed_out;
   pkt_word_t   pkt [9];
   pkt_word_t   exp_q [$];
   int          kind_q [$];
   int          n_words;
   int          kind;
   int          words_seen;
   int          err_total;
   int          pkt_count [NUM_KINDS];
   int          err_count [NUM_KINDS];
   string       beh_name [NUM_KINDS] = '{"non-unicast to cpu", "unicast ttl expiry to cpu",
      "mpls command 0", "mpls command 1 swap", "unicast non-mpls", "order under back-pressure"};

   tb_clock u_clock (.clk(clk));

   mpls_proc u_dut (
      .clk(clk), .reset(reset), .in_word(in_word), .in_wr(in_wr), .in_rdy(in_rdy),
      .out_word(out_word), .out_wr(out_wr), .out_rdy(out_rdy),
      .bram_dst_mac(bram_dst_mac), .mplsword(mplsword), .unicast_out(unicast_out),
      .ttl_stat_out(ttl_stat_out)
   );

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = lcg(rng);
      return rng;
   endfunction

   ////////////////////
   // packet, sideband and expected words
   task automatic build_packet(input int num);
      logic [31:0] r;
      logic [63:0] d64;
      logic [95:0] wide;
      logic [2:0]  src;
      logic [2:0]  port;
      logic [3:0]  cmd;
      logic [19:0] swap;
      logic [7:0]  ttl;
      logic        uni;
      logic        is_mpls;
      logic        cpu;
      pkt_word_t   w;
      int          i;
      kind = num % 5;    // behaviors 1 to 5 in turn
      r = next_rand();
      n_words = 4 + int'(r[31:28]) % 6;
      for (i = 0; i < n_words; i++) begin
         pkt[i].data = {next_rand(), next_rand()};
         pkt[i].ctrl = 8'h00;
      end
      pkt[0].ctrl = `HDR_CTRL;
      r = next_rand();
      pkt[n_words-1].ctrl = 8'h01 << r[31:29];   // end marker
      is_mpls = r[27];
      cmd     = {3'b000, r[12]};
      port    = r[10:8];
      ttl     = (r[23:16] < 8'd2) ? 8'd2 : r[23:16];
      uni     = 1'b1;
      case (kind)
         0: begin
            uni = 1'b0;
            ttl = r[23:16];
         end
         1: ttl = {7'd0, r[16]};
         2: begin
            is_mpls = 1'b1;
            cmd     = 4'd0;
         end
         3: begin
            is_mpls = 1'b1;
            cmd     = 4'd1;
         end
         default: is_mpls = 1'b0;
      endcase
      pkt[2].data[31:16] = is_mpls ? `ETHTYPE_MPLS : 16'h0800;
      src  = pkt[0].data[`SRC_PORT_POS +: 3];
      r    = next_rand();
      swap = r[31:12];
      wide = {next_rand(), next_rand(), next_rand()};
      d64  = {next_rand(), next_rand()};
      // sideband held until this packet drains
      mplsword        = wide[71:0];
      mplsword[71:68] = cmd;
      mplsword[60:58] = port;
      mplsword[49:30] = swap;
      bram_dst_mac    = d64[47:0];
      unicast_out     = uni;
      ttl_stat_out    = ttl;
      pkt_count[kind]++;
      cpu = !uni || (ttl < 8'd2);
      for (i = 0; i < n_words; i++) begin
         w = pkt[i];
         if (i == 0) begin
            if (cpu) w.data[`DST_PORT_POS +: 8] = 8'h01 << 3'(src + 3'd1);
            else w.data[`DST_PORT_POS +: 8] = 8'h01 << port;
         end else if (!cpu && i == 1) begin
            w.data[63:16] = bram_dst_mac;    // table mac
         end else if (!cpu && is_mpls && i == 2 && cmd == 4'd1) begin
            w.data[15:0] = swap[19:4];
         end else if (!cpu && is_mpls && i == 3) begin
            if (cmd == 4'd1) w.data[63:60] = swap[3:0];
            w.data[55:48] = pkt[3].data[55:48] - 8'd1;   // label ttl
         end
         exp_q.push_back(w);
         kind_q.push_back(kind);
      end
   endtask

   task automatic send_packet();
      int i;
      int n;
      for (i = 0; i < n_words && !timed_out; i++) begin
         n = 0;
         while (!in_rdy && n < WAIT_LIMIT) begin
            in_wr = 1'b0;
            @(posedge clk) #1;
            n++;
         end
         if (!in_rdy) begin
            $display("timeout: in_rdy stayed low while a packet was being written");
            timed_out = 1'b1;
            err_count[5]++;
         end else begin
            in_word = pkt[i];
            in_wr   = 1'b1;
            @(posedge clk) #1;
         end
      end
      in_wr = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: %0d expected output words never appeared", exp_q.size());
         timed_out = 1'b1;
         err_count[5]++;
      end
      #1;
   endtask

   ////////////////////
   // back-pressure
   initial begin
      out_rdy = 1'b0;
      rdy_rng = SEED;
      forever begin
         @(posedge clk) #1;
         rdy_rng = lcg(rdy_rng);
         out_rdy = (rdy_rng[31:30] != 2'b00);   // ready about 3 cycles in 4
      end
   end

   always @(posedge clk) begin
      rdy_at_edge = out_rdy;
   end

   ////////////////////
   // output monitor sampled mid-cycle
   always @(negedge clk) begin
      pkt_word_t w;
      int        k;
      // at most one packet of 9 words is ever in the 32 deep fifo
      if (!reset && in_rdy !== 1'b1) begin
         $display("[FAIL] t=%0t in_rdy: got %b, expected %b", $time, in_rdy, 1'b1);
         err_count[5]++;
      end
      if (!reset && out_wr) begin
         if (!rdy_at_edge) begin
            $display("out_wr at %0t without out_rdy high in the cycle before", $time);
            err_count[5]++;
         end
         if (exp_q.size() == 0) begin
            $display("output word %h at %0t was not expected", out_word, $time);
            err_count[5]++;
         end else begin
            w = exp_q.pop_front();
            k = kind_q.pop_front();
            words_seen++;
            if (out_word !== w) begin
               $display("[FAIL] t=%0t out_word: got %h, expected %h", $time, out_word, w);
               err_count[k]++;
            end
         end
      end
   end

   initial begin
      int p;
      int b;
      reset        = 1'b1;
      in_word      = '0;
      in_wr        = 1'b0;
      bram_dst_mac = '0;
      mplsword     = '0;
      unicast_out  = 1'b0;
      ttl_stat_out = 8'd0;
      rng          = SEED;
      timed_out    = 1'b0;
      words_seen   = 0;
      err_total    = 0;
      for (b = 0; b < NUM_KINDS; b++) begin
         pkt_count[b] = 0;
         err_count[b] = 0;
      end
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // one packet at a time with its sideband held until it leaves
      for (p = 0; p < NUM_PKTS && !timed_out; p++) begin
         build_packet(p);
         send_packet();
         if (!timed_out) wait_drain();
      end

      for (b = 0; b < 5; b++) begin
         $display("behavior %0d %s: %0d packets, %0d errors, %s", b + 1, beh_name[b],
            pkt_count[b], err_count[b], (err_count[b] == 0) ? "ok" : "failed");
         err_total += err_count[b];
      end
      $display("behavior 6 %s: %0d words, %0d errors, %s", beh_name[5], words_seen,
         err_count[5], (err_count[5] == 0) ? "ok" : "failed");
      err_total += err_count[5];
      $display("summary: %0d packets, %0d words checked, %0d errors", p, words_seen, err_total);
      if (err_total == 0 && !timed_out) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 100   // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire
